// ==== compile.f ====
store_set_pkg.sv
sst.sv
predictor_table.sv
ssit_stage.sv
lfst_stage.sv
violation_trainer.sv
store_set_predictor.sv
store_set_predictor_tb.sv

// ==== store_set_testdata.txt ====
# D pc is_store rob_tag | expected ssid_valid ssid dep_valid dep_tag ; C ssid rob_tag
# V load_pc store_pc ; I idle cycle ; every field in hex, one operation per cycle
D 00000100 0 01 0 00 0 00
D 00000104 1 02 0 00 0 00
D 0000a5a4 0 03 0 00 0 00
V 00000100 00000104
D 00000180 0 0a 0 00 0 00
V 00000108 0000010c
V 00001204 00000114
V 00000118 0000011c
D 00000184 1 0b 0 00 0 00
I
D 00000100 0 10 1 00 0 00
D 00000108 0 11 1 20 0 00
D 00001204 0 12 1 10 0 00
D 00000118 0 13 1 30 0 00
D 00000104 1 14 1 00 0 00
D 0000010c 1 15 1 20 0 00
D 00000114 1 16 1 10 0 00
D 0000011c 1 17 1 30 0 00
D 00000118 0 18 1 30 1 17
D 0000011c 1 20 1 30 0 00
D 00000118 0 21 1 30 1 20
C 30 17
D 00000118 0 22 1 30 1 20
C 30 20
D 00000118 0 23 1 30 0 00
D 0000011c 1 24 1 30 0 00
D 0000011c 1 25 1 30 0 00
C 30 24
D 00000118 0 26 1 30 1 25
D 00000100 0 27 1 00 1 14
I
V 00000140 00000144
I
I
D 00000140 0 28 1 28 0 00
D 00000144 1 29 1 28 0 00
D 00000140 0 2a 1 28 1 29

// ==== store_set_predictor_tb.sv ====
// testbench for the store-set predictor
// replays store_set_testdata.txt line by line, one operation per cycle,
// and checks every dispatch response two cycles after its dispatch
// violation lines wait for viol_ready before they are sent
`timescale 1ns/100ps

module store_set_predictor_tb;

    localparam int MAX_LINES  = 64;
    localparam int DRIVE_SKEW = 1;

    logic                    CLK;
    logic                    nRST;
    logic                    disp_valid;
    store_set_pkg::pc_t      disp_pc;
    logic                    disp_is_store;
    store_set_pkg::rob_tag_t disp_rob_tag;
    logic                    resp_valid;
    logic                    resp_is_store;
    store_set_pkg::rob_tag_t resp_rob_tag;
    logic                    resp_ssid_valid;
    store_set_pkg::ssid_t    resp_ssid;
    logic                    resp_dep_valid;
    store_set_pkg::rob_tag_t resp_dep_rob_tag;
    logic                    commit_valid;
    store_set_pkg::ssid_t    commit_ssid;
    store_set_pkg::rob_tag_t commit_rob_tag;
    logic                    viol_valid;
    logic                    viol_ready;
    store_set_pkg::pc_t      viol_load_pc;
    store_set_pkg::pc_t      viol_store_pc;

    // --------------------
    // test data and expected responses

    byte         ops [MAX_LINES];
    logic [31:0] fields [MAX_LINES][7];
    int          line_count;
    int          cycle_count = 0;
    int          cycle_limit = 100;
    // cycle the last violation was presented, far in the past at start
    int          viol_cycle  = -10;

    // one entry per dispatch still in flight, oldest first
    int                      exp_due [$];
    logic                    exp_is_store [$];
    store_set_pkg::rob_tag_t exp_rob_tag [$];
    logic                    exp_ssid_valid [$];
    store_set_pkg::ssid_t    exp_ssid [$];
    logic                    exp_dep_valid [$];
    store_set_pkg::rob_tag_t exp_dep_tag [$];

    store_set_predictor store_set_predictor_inst (
        .CLK              (CLK),
        .nRST             (nRST),
        .disp_valid       (disp_valid),
        .disp_pc          (disp_pc),
        .disp_is_store    (disp_is_store),
        .disp_rob_tag     (disp_rob_tag),
        .resp_valid       (resp_valid),
        .resp_is_store    (resp_is_store),
        .resp_rob_tag     (resp_rob_tag),
        .resp_ssid_valid  (resp_ssid_valid),
        .resp_ssid        (resp_ssid),
        .resp_dep_valid   (resp_dep_valid),
        .resp_dep_rob_tag (resp_dep_rob_tag),
        .commit_valid     (commit_valid),
        .commit_ssid      (commit_ssid),
        .commit_rob_tag   (commit_rob_tag),
        .viol_valid       (viol_valid),
        .viol_ready       (viol_ready),
        .viol_load_pc     (viol_load_pc),
        .viol_store_pc    (viol_store_pc)
    );

    // 8 ns period
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // --------------------
    // helpers

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string what, input logic exp_bit, input logic got_bit);
        if (got_bit !== exp_bit)
            fail_run($sformatf("Fail %0t: %s is %b, expected %b", $time, what, got_bit, exp_bit));
    endtask

    // value only compared when it is expected valid
    task automatic check_ssid(input string what, input logic exp_valid,
                              input store_set_pkg::ssid_t exp_id,
                              input logic got_valid, input store_set_pkg::ssid_t got_id);
        if (got_valid !== exp_valid)
            fail_run($sformatf("Fail %0t: %s valid is %b, expected %b",
                               $time, what, got_valid, exp_valid));
        else if (exp_valid && got_id !== exp_id)
            fail_run($sformatf("Fail %0t: %s is %0d, expected %0d", $time, what, got_id, exp_id));
    endtask

    task automatic check_rob_tag(input string what, input logic exp_valid,
                                 input store_set_pkg::rob_tag_t exp_tag,
                                 input logic got_valid, input store_set_pkg::rob_tag_t got_tag);
        if (got_valid !== exp_valid)
            fail_run($sformatf("Fail %0t: %s valid is %b, expected %b",
                               $time, what, got_valid, exp_valid));
        else if (exp_valid && got_tag !== exp_tag)
            fail_run($sformatf("Fail %0t: %s is %0h, expected %0h", $time, what, got_tag, exp_tag));
    endtask

    // lands just after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_SKEW;
    endtask

    task automatic clear_inputs();
        disp_valid   = 1'b0;
        commit_valid = 1'b0;
        viol_valid   = 1'b0;
    endtask

    // --------------------
    // file reader

    task automatic load_testdata();
        int                fd;
        int                code;
        int                want;
        byte               op;
        logic [8*160-1:0]  rest;
        fd = $fopen("store_set_testdata.txt", "r");
        if (fd == 0)
            fail_run("could not open store_set_testdata.txt");
        line_count = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1)
                break;
            if (op == "#") begin
                // column notes
                code = $fgets(rest, fd);
            end else begin
                if (line_count >= MAX_LINES)
                    fail_run("test data has more lines than the testbench can hold");
                ops[line_count] = op;
                want = 0;
                code = 0;
                case (op)
                    "D": begin
                        want = 7;
                        code = $fscanf(fd, " %h %h %h %h %h %h %h",
                                       fields[line_count][0], fields[line_count][1],
                                       fields[line_count][2], fields[line_count][3],
                                       fields[line_count][4], fields[line_count][5],
                                       fields[line_count][6]);
                    end
                    "C", "V": begin
                        want = 2;
                        code = $fscanf(fd, " %h %h",
                                       fields[line_count][0], fields[line_count][1]);
                    end
                    "I": ;
                    default: fail_run($sformatf("unknown opcode %c in test data", op));
                endcase
                if (code != want)
                    fail_run($sformatf("test data line %0d is malformed", line_count + 1));
                line_count++;
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // line drivers

    task automatic apply_dispatch(input int n);
        disp_valid    = 1'b1;
        disp_pc       = fields[n][0];
        disp_is_store = fields[n][1][0];
        disp_rob_tag  = store_set_pkg::rob_tag_t'(fields[n][2]);
        // latency fixed at two cycles
        exp_due.push_back(cycle_count + 2);
        exp_is_store.push_back(fields[n][1][0]);
        exp_rob_tag.push_back(store_set_pkg::rob_tag_t'(fields[n][2]));
        exp_ssid_valid.push_back(fields[n][3][0]);
        exp_ssid.push_back(store_set_pkg::ssid_t'(fields[n][4]));
        exp_dep_valid.push_back(fields[n][5][0]);
        exp_dep_tag.push_back(store_set_pkg::rob_tag_t'(fields[n][6]));
    endtask

    task automatic apply_commit(input int n);
        commit_valid   = 1'b1;
        commit_ssid    = store_set_pkg::ssid_t'(fields[n][0]);
        commit_rob_tag = store_set_pkg::rob_tag_t'(fields[n][1]);
    endtask

    // held off while the trainer writes the previous report
    task automatic apply_violation(input int n);
        while (!viol_ready)
            next_cycle();
        viol_valid    = 1'b1;
        viol_load_pc  = fields[n][0];
        viol_store_pc = fields[n][1];
        viol_cycle    = cycle_count;
    endtask

    // --------------------
    // cycle count and timeout

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
            fail_run($sformatf("timeout, the test did not finish within %0d cycles", cycle_limit));
    end

    // --------------------
    // response check

    // responses are registered on the rising edge, stable here
    always @(negedge CLK) begin
        if (nRST) begin
            // ready drops for the two write cycles after an accept
            check_flag("viol_ready",
                       !(cycle_count == viol_cycle + 1 || cycle_count == viol_cycle + 2),
                       viol_ready);
            if (resp_valid) begin
                if (exp_due.size() == 0)
                    fail_run("a response arrived with no dispatch waiting for one");
                else if (exp_due[0] != cycle_count)
                    fail_run($sformatf("response came in cycle %0d, it was due in cycle %0d",
                                       cycle_count, exp_due[0]));
                check_flag("resp_is_store", exp_is_store[0], resp_is_store);
                check_rob_tag("resp_rob_tag", 1'b1, exp_rob_tag[0], 1'b1, resp_rob_tag);
                check_ssid("resp_ssid", exp_ssid_valid[0], exp_ssid[0],
                           resp_ssid_valid, resp_ssid);
                check_rob_tag("resp_dep_rob_tag", exp_dep_valid[0], exp_dep_tag[0],
                              resp_dep_valid, resp_dep_rob_tag);
                void'(exp_due.pop_front());
                void'(exp_is_store.pop_front());
                void'(exp_rob_tag.pop_front());
                void'(exp_ssid_valid.pop_front());
                void'(exp_ssid.pop_front());
                void'(exp_dep_valid.pop_front());
                void'(exp_dep_tag.pop_front());
            end else if (exp_due.size() != 0 && exp_due[0] <= cycle_count) begin
                fail_run("a dispatch got no response two cycles after it was sent");
            end
        end
    end

    // --------------------
    // main sequence

    initial begin
        nRST           = 1'b0;
        disp_valid     = 1'b0;
        disp_pc        = '0;
        disp_is_store  = 1'b0;
        disp_rob_tag   = '0;
        commit_valid   = 1'b0;
        commit_ssid    = '0;
        commit_rob_tag = '0;
        viol_valid     = 1'b0;
        viol_load_pc   = '0;
        viol_store_pc  = '0;

        load_testdata();
        cycle_limit = 8 * line_count + 100;

        repeat (10) @(posedge CLK);
        #DRIVE_SKEW;
        nRST = 1'b1;

        for (int i = 0; i < line_count; i++) begin
            clear_inputs();
            case (ops[i])
                "D": apply_dispatch(i);
                "C": apply_commit(i);
                "V": apply_violation(i);
                default: ;
            endcase
            next_cycle();
        end
        clear_inputs();

        // drain the pipeline
        while (exp_due.size() != 0)
            next_cycle();
        // one more cycle to catch a stray response
        next_cycle();

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== store_set_predictor.sv ====
// store-set memory dependence predictor, top level
// dispatch responds two cycles later with the op's ssid and, for loads,
// the ROB tag of the store it must wait for
// commits clear the LFST, violations train the SSIT
`timescale 1ns/100ps

module store_set_predictor (
    input  logic                    CLK,
    input  logic                    nRST,

    // dispatch
    input  logic                    disp_valid,
    input  store_set_pkg::pc_t      disp_pc,
    input  logic                    disp_is_store,
    input  store_set_pkg::rob_tag_t disp_rob_tag,

    // response
    output logic                    resp_valid,
    output logic                    resp_is_store,
    output store_set_pkg::rob_tag_t resp_rob_tag,
    output logic                    resp_ssid_valid,
    output store_set_pkg::ssid_t    resp_ssid,
    output logic                    resp_dep_valid,
    output store_set_pkg::rob_tag_t resp_dep_rob_tag,

    // commit
    input  logic                    commit_valid,
    input  store_set_pkg::ssid_t    commit_ssid,
    input  store_set_pkg::rob_tag_t commit_rob_tag,

    // violation
    input  logic                    viol_valid,
    output logic                    viol_ready,
    input  store_set_pkg::pc_t      viol_load_pc,
    input  store_set_pkg::pc_t      viol_store_pc
);

    // --------------------
    // wires

    // SSIT ports
    store_set_pkg::ssit_index_t  ssit_rd_index;
    store_set_pkg::ssit_entry_t  ssit_rd_entry;
    logic                        ssit_wr_valid;
    store_set_pkg::ssit_index_t  ssit_wr_index;
    store_set_pkg::ssit_entry_t  ssit_wr_entry;

    // stage 1 -> stage 2
    logic                        s2_valid;
    logic                        s2_is_store;
    store_set_pkg::rob_tag_t     s2_rob_tag;
    logic                        s2_ssid_valid;
    store_set_pkg::ssid_t        s2_ssid;

    // LFST ports
    store_set_pkg::ssid_t        lfst_rd_index;
    store_set_pkg::lfst_entry_t  lfst_rd_entry;
    store_set_pkg::ssid_t        lfst_rd2_index;
    store_set_pkg::lfst_entry_t  lfst_rd2_entry;
    logic                        lfst_wr_valid;
    store_set_pkg::ssid_t        lfst_wr_index;
    store_set_pkg::lfst_entry_t  lfst_wr_entry;

    // allocator
    logic                        new_ssid_valid;
    store_set_pkg::ssid_t        new_ssid;
    logic                        touch_ssid_valid;
    store_set_pkg::ssid_t        touch_ssid;

    // --------------------
    // tables

    // pc hash -> ssid, second read unused
    predictor_table #(
        .entry_t (store_set_pkg::ssit_entry_t),
        .DEPTH   (store_set_pkg::SSIT_ENTRIES)
    ) ssit_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .rd_index  (ssit_rd_index),
        .rd_entry  (ssit_rd_entry),
        .rd2_index ('0),
        .rd2_entry (),
        .wr_valid  (ssit_wr_valid),
        .wr_index  (ssit_wr_index),
        .wr_entry  (ssit_wr_entry)
    );

    // ssid -> last store tag
    predictor_table #(
        .entry_t (store_set_pkg::lfst_entry_t),
        .DEPTH   (store_set_pkg::STORE_SET_COUNT)
    ) lfst_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .rd_index  (lfst_rd_index),
        .rd_entry  (lfst_rd_entry),
        .rd2_index (lfst_rd2_index),
        .rd2_entry (lfst_rd2_entry),
        .wr_valid  (lfst_wr_valid),
        .wr_index  (lfst_wr_index),
        .wr_entry  (lfst_wr_entry)
    );

    // --------------------
    // dispatch pipeline

    ssit_stage ssit_stage_inst (
        .CLK              (CLK),
        .nRST             (nRST),
        .disp_valid       (disp_valid),
        .disp_pc          (disp_pc),
        .disp_is_store    (disp_is_store),
        .disp_rob_tag     (disp_rob_tag),
        .ssit_rd_index    (ssit_rd_index),
        .ssit_rd_entry    (ssit_rd_entry),
        .s2_valid         (s2_valid),
        .s2_is_store      (s2_is_store),
        .s2_rob_tag       (s2_rob_tag),
        .s2_ssid_valid    (s2_ssid_valid),
        .s2_ssid          (s2_ssid),
        .touch_ssid_valid (touch_ssid_valid),
        .touch_ssid       (touch_ssid)
    );

    lfst_stage lfst_stage_inst (
        .CLK              (CLK),
        .nRST             (nRST),
        .s2_valid         (s2_valid),
        .s2_is_store      (s2_is_store),
        .s2_rob_tag       (s2_rob_tag),
        .s2_ssid_valid    (s2_ssid_valid),
        .s2_ssid          (s2_ssid),
        .lfst_rd_index    (lfst_rd_index),
        .lfst_rd_entry    (lfst_rd_entry),
        .lfst_rd2_index   (lfst_rd2_index),
        .lfst_rd2_entry   (lfst_rd2_entry),
        .lfst_wr_valid    (lfst_wr_valid),
        .lfst_wr_index    (lfst_wr_index),
        .lfst_wr_entry    (lfst_wr_entry),
        .commit_valid     (commit_valid),
        .commit_ssid      (commit_ssid),
        .commit_rob_tag   (commit_rob_tag),
        .resp_valid       (resp_valid),
        .resp_is_store    (resp_is_store),
        .resp_rob_tag     (resp_rob_tag),
        .resp_ssid_valid  (resp_ssid_valid),
        .resp_ssid        (resp_ssid),
        .resp_dep_valid   (resp_dep_valid),
        .resp_dep_rob_tag (resp_dep_rob_tag)
    );

    // --------------------
    // training

    violation_trainer violation_trainer_inst (
        .CLK            (CLK),
        .nRST           (nRST),
        .viol_valid     (viol_valid),
        .viol_ready     (viol_ready),
        .viol_load_pc   (viol_load_pc),
        .viol_store_pc  (viol_store_pc),
        .new_ssid       (new_ssid),
        .new_ssid_valid (new_ssid_valid),
        .ssit_wr_valid  (ssit_wr_valid),
        .ssit_wr_index  (ssit_wr_index),
        .ssit_wr_entry  (ssit_wr_entry)
    );

    sst sst_inst (
        .CLK              (CLK),
        .nRST             (nRST),
        .new_ssid_valid   (new_ssid_valid),
        .new_ssid         (new_ssid),
        .touch_ssid_valid (touch_ssid_valid),
        .touch_ssid       (touch_ssid)
    );

endmodule

// ==== violation_trainer.sv ====
// trains the SSIT on a memory-order violation
// takes a fresh ssid from the allocator, then writes it into the
// load pc's entry and the store pc's entry on the next two cycles
`timescale 1ns/100ps

module violation_trainer (
    input  logic                        CLK,
    input  logic                        nRST,

    // violation report
    input  logic                        viol_valid,
    output logic                        viol_ready,
    input  store_set_pkg::pc_t          viol_load_pc,
    input  store_set_pkg::pc_t          viol_store_pc,

    // allocator
    input  store_set_pkg::ssid_t        new_ssid,
    output logic                        new_ssid_valid,

    // SSIT write
    output logic                        ssit_wr_valid,
    output store_set_pkg::ssit_index_t  ssit_wr_index,
    output store_set_pkg::ssit_entry_t  ssit_wr_entry
);

    typedef enum logic [1:0] {
        IDLE,
        WR_LOAD,
        WR_STORE
    } state_t;

    state_t                     state;
    state_t                     next_state;
    logic                       accept;
    store_set_pkg::ssid_t       held_ssid;
    store_set_pkg::ssit_index_t load_index;
    store_set_pkg::pc_t         store_pc;

    // --------------------
    // handshake

    assign viol_ready     = (state == IDLE);
    assign accept         = viol_valid & viol_ready;
    // allocator advances on the accepting edge
    assign new_ssid_valid = accept;

    // --------------------
    // FSM

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (accept) next_state = WR_LOAD;
            WR_LOAD:  next_state = WR_STORE;
            WR_STORE: next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // report held until both entries are written
    always_ff @(posedge CLK) begin
        if (accept) begin
            held_ssid  <= new_ssid;
            load_index <= store_set_pkg::ssit_hash(viol_load_pc);
            store_pc   <= viol_store_pc;
        end
    end

    // --------------------
    // SSIT write

    // load entry first, store entry second, same fresh ssid
    assign ssit_wr_valid = (state == WR_LOAD) | (state == WR_STORE);
    assign ssit_wr_index = (state == WR_LOAD) ? load_index
                                              : store_set_pkg::ssit_hash(store_pc);
    assign ssit_wr_entry = '{valid: 1'b1, ssid: held_ssid};

    // --------------------
    // checks

    // an accepted report writes exactly two cycles, then goes idle
    a_two_writes: assert property (
        @(posedge CLK) disable iff (!nRST)
        accept |=> ssit_wr_valid ##1 ssit_wr_valid ##1 (!ssit_wr_valid && viol_ready)
    ) else $error("trainer write sequence is not two cycles");

endmodule

// ==== lfst_stage.sv ====
// dispatch stage 2 of the predictor
// reads the LFST with the op's ssid and registers the dependency response
// owns the LFST write: store records first, commit clears otherwise
`timescale 1ns/100ps

module lfst_stage (
    input  logic                        CLK,
    input  logic                        nRST,

    // from stage 1
    input  logic                        s2_valid,
    input  logic                        s2_is_store,
    input  store_set_pkg::rob_tag_t     s2_rob_tag,
    input  logic                        s2_ssid_valid,
    input  store_set_pkg::ssid_t        s2_ssid,

    // LFST reads, op lookup and commit check
    output store_set_pkg::ssid_t        lfst_rd_index,
    input  store_set_pkg::lfst_entry_t  lfst_rd_entry,
    output store_set_pkg::ssid_t        lfst_rd2_index,
    input  store_set_pkg::lfst_entry_t  lfst_rd2_entry,

    // LFST write
    output logic                        lfst_wr_valid,
    output store_set_pkg::ssid_t        lfst_wr_index,
    output store_set_pkg::lfst_entry_t  lfst_wr_entry,

    // commit
    input  logic                        commit_valid,
    input  store_set_pkg::ssid_t        commit_ssid,
    input  store_set_pkg::rob_tag_t     commit_rob_tag,

    // response
    output logic                        resp_valid,
    output logic                        resp_is_store,
    output store_set_pkg::rob_tag_t     resp_rob_tag,
    output logic                        resp_ssid_valid,
    output store_set_pkg::ssid_t        resp_ssid,
    output logic                        resp_dep_valid,
    output store_set_pkg::rob_tag_t     resp_dep_rob_tag
);

    logic store_record;
    logic commit_clear;
    logic dep_hit;

    // --------------------
    // lookup

    assign lfst_rd_index  = s2_ssid;
    assign lfst_rd2_index = commit_ssid;

    // only loads wait, and only on a live store in their set
    assign dep_hit = s2_valid & ~s2_is_store & s2_ssid_valid & lfst_rd_entry.valid;

    // --------------------
    // write select

    // stores in a known set become the set's last store
    assign store_record = s2_valid & s2_is_store & s2_ssid_valid;

    // commit clears only if no younger store has replaced it
    assign commit_clear = commit_valid & lfst_rd2_entry.valid
                        & (lfst_rd2_entry.rob_tag == commit_rob_tag);

    // store wins, a same-cycle commit is dropped
    assign lfst_wr_valid = store_record | commit_clear;
    assign lfst_wr_index = store_record ? s2_ssid : commit_ssid;
    assign lfst_wr_entry = store_record
                         ? store_set_pkg::lfst_entry_t'{valid: 1'b1, rob_tag: s2_rob_tag}
                         : '0;

    // --------------------
    // response register

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s2_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (s2_valid) begin
            resp_is_store    <= s2_is_store;
            resp_rob_tag     <= s2_rob_tag;
            resp_ssid_valid  <= s2_ssid_valid;
            resp_ssid        <= s2_ssid;
            resp_dep_valid   <= dep_hit;
            resp_dep_rob_tag <= lfst_rd_entry.rob_tag;
        end
    end

    // --------------------
    // checks

    // a recorded store is what the next op in the same set reads
    a_store_visible: assert property (
        @(posedge CLK) disable iff (!nRST)
        store_record ##1 (s2_valid && s2_ssid_valid && (s2_ssid == $past(s2_ssid)))
        |-> (lfst_rd_entry.valid && (lfst_rd_entry.rob_tag == $past(s2_rob_tag)))
    ) else $error("recorded store tag not visible to the next op in its set");

endmodule

// ==== ssit_stage.sv ====
// dispatch stage 1 of the predictor
// hashes the dispatching pc, reads the SSIT and registers the op with its ssid
// a registered hit also refreshes that ssid in the allocator
`timescale 1ns/100ps

module ssit_stage (
    input  logic                        CLK,
    input  logic                        nRST,

    // dispatch in
    input  logic                        disp_valid,
    input  store_set_pkg::pc_t          disp_pc,
    input  logic                        disp_is_store,
    input  store_set_pkg::rob_tag_t     disp_rob_tag,

    // SSIT read
    output store_set_pkg::ssit_index_t  ssit_rd_index,
    input  store_set_pkg::ssit_entry_t  ssit_rd_entry,

    // to stage 2
    output logic                        s2_valid,
    output logic                        s2_is_store,
    output store_set_pkg::rob_tag_t     s2_rob_tag,
    output logic                        s2_ssid_valid,
    output store_set_pkg::ssid_t        s2_ssid,

    // allocator touch
    output logic                        touch_ssid_valid,
    output store_set_pkg::ssid_t        touch_ssid
);

    // --------------------
    // lookup

    assign ssit_rd_index = store_set_pkg::ssit_hash(disp_pc);

    // --------------------
    // stage register

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= disp_valid;
        end
    end

    // op payload, only meaningful under s2_valid
    always_ff @(posedge CLK) begin
        if (disp_valid) begin
            s2_is_store   <= disp_is_store;
            s2_rob_tag    <= disp_rob_tag;
            s2_ssid_valid <= ssit_rd_entry.valid;
            s2_ssid       <= ssit_rd_entry.ssid;
        end
    end

    // --------------------
    // touch

    // any op that hit keeps its set warm
    assign touch_ssid_valid = s2_valid & s2_ssid_valid;
    assign touch_ssid       = s2_ssid;

endmodule

// ==== predictor_table.sv ====
// register-file table shared by the SSIT and the LFST
// two combinational reads, one write at the clock edge
// entries clear to zero, which makes every entry invalid
`timescale 1ns/100ps

module predictor_table #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // primary read
    input  logic [$clog2(DEPTH)-1:0] rd_index,
    output entry_t                   rd_entry,

    // secondary read, used by the LFST commit check
    input  logic [$clog2(DEPTH)-1:0] rd2_index,
    output entry_t                   rd2_entry,

    // write
    input  logic                     wr_valid,
    input  logic [$clog2(DEPTH)-1:0] wr_index,
    input  entry_t                   wr_entry
);

    entry_t entries [DEPTH];

    // --------------------
    // reads

    // a write shows up on the read the cycle after it lands
    assign rd_entry  = entries[rd_index];
    assign rd2_entry = entries[rd2_index];

    // --------------------
    // write

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            entries <= '{default: '0};
        end else if (wr_valid) begin
            entries[wr_index] <= wr_entry;
        end
    end

endmodule

// ==== sst.sv ====
// store set tracker, a tree pseudo-LRU allocator of store set IDs
// new_ssid always shows the next ID to hand out; pulse new_ssid_valid to take it
// touch marks an ID as recently used so it is not reallocated soon
`timescale 1ns/100ps

module sst (
    input  logic                 CLK,
    input  logic                 nRST,

    // allocation
    input  logic                 new_ssid_valid,
    output store_set_pkg::ssid_t new_ssid,

    // recent use
    input  logic                 touch_ssid_valid,
    input  store_set_pkg::ssid_t touch_ssid
);

    // --------------------
    // tree state

    // heap order, root at node 0, children of n at 2n+1 and 2n+2
    // one tree level per ssid bit, msb at the root
    logic [store_set_pkg::PLRU_NODES-1:0] plru;

    // node that decides each ssid bit, along the advertised path
    logic [store_set_pkg::SSID_WIDTH-1:0] alloc_node [store_set_pkg::SSID_WIDTH];
    // same, along the touched path
    logic [store_set_pkg::SSID_WIDTH-1:0] touch_node [store_set_pkg::SSID_WIDTH];

    // --------------------
    // path walk

    for (genvar b = store_set_pkg::SSID_WIDTH - 1; b >= 0; b--) begin : g_level
        // each level's bit picks the branch taken
        assign new_ssid[b] = plru[alloc_node[b]];

        if (b == store_set_pkg::SSID_WIDTH - 1) begin : g_root
            assign alloc_node[b] = '0;
            assign touch_node[b] = '0;
        end else begin : g_child
            // left child is 2n+1, right adds one more
            assign alloc_node[b] = store_set_pkg::ssid_t'(
                {alloc_node[b+1], 1'b1} + {{store_set_pkg::SSID_WIDTH{1'b0}}, new_ssid[b+1]});
            assign touch_node[b] = store_set_pkg::ssid_t'(
                {touch_node[b+1], 1'b1} + {{store_set_pkg::SSID_WIDTH{1'b0}}, touch_ssid[b+1]});
        end
    end

    // --------------------
    // update

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            // first allocation is ssid 0
            plru <= '0;
        end else if (new_ssid_valid) begin
            // flip every node on the handed-out path
            for (int b = 0; b < store_set_pkg::SSID_WIDTH; b++) begin
                plru[alloc_node[b]] <= ~plru[alloc_node[b]];
            end
        end else if (touch_ssid_valid) begin
            // point each node away from the touched id
            // dropped when an allocation lands in the same cycle
            for (int b = 0; b < store_set_pkg::SSID_WIDTH; b++) begin
                plru[touch_node[b]] <= ~touch_ssid[b];
            end
        end
    end

    // --------------------
    // checks

    // trainer must stay quiet while the core is held in reset
    a_no_alloc_in_reset: assert property (
        @(posedge CLK) !nRST |-> !new_ssid_valid
    ) else $error("sst allocation requested during reset");

endmodule

// ==== store_set_pkg.sv ====
// shared widths, payload types and index hash for the store-set predictor
// every predictor file refers to these by scoped name
package store_set_pkg;

    // --------------------
    // sizes

    // number of store sets tracked by the allocator
    localparam int STORE_SET_COUNT = 64;
    localparam int SSID_WIDTH = $clog2(STORE_SET_COUNT);
    // pseudo-LRU tree nodes, one fewer than leaves
    localparam int PLRU_NODES = STORE_SET_COUNT - 1;

    localparam int SSIT_ENTRIES = 128;
    localparam int SSIT_INDEX_WIDTH = $clog2(SSIT_ENTRIES);

    localparam int PC_WIDTH = 32;
    localparam int ROB_TAG_WIDTH = 7;

    // --------------------
    // types

    typedef logic [SSID_WIDTH-1:0]       ssid_t;
    typedef logic [PC_WIDTH-1:0]         pc_t;
    typedef logic [ROB_TAG_WIDTH-1:0]    rob_tag_t;
    typedef logic [SSIT_INDEX_WIDTH-1:0] ssit_index_t;

    // pc -> store set mapping
    typedef struct packed {
        logic  valid;
        ssid_t ssid;
    } ssit_entry_t;

    // store set -> youngest in-flight store
    typedef struct packed {
        logic     valid;
        rob_tag_t rob_tag;
    } lfst_entry_t;

    // --------------------
    // hash

    // word-aligned pc, low index field folded with the field above it
    function automatic ssit_index_t ssit_hash(input pc_t pc);
        return pc[SSIT_INDEX_WIDTH+1:2] ^ pc[2*SSIT_INDEX_WIDTH+1:SSIT_INDEX_WIDTH+2];
    endfunction

endpackage
